// ==== project.f ====
source/csr_pkg.sv
source/csr_alu.sv
source/trap_ctrl.sv
source/csr_regfile.sv
source/csr_unit.sv
verif/csr_unit_tb.sv

// ==== source/csr_alu.sv ====
`timescale 1ns/1ps

module csr_alu
  import csr_pkg::*;
(
  input  csr_op_t         op,
  input  logic [xlen-1:0] old,
  input  logic [xlen-1:0] src,
  input  logic [4:0]      zimm,
  output logic            we,
  output logic [xlen-1:0] wdata
);

  logic            is_imm;
  logic [xlen-1:0] operand;
  logic            operand_nz;

  // immediate forms take the zero-extended uimm field
  always_comb
  begin
    case (op)
      op_rwi, op_rsi, op_rci:
      begin
        is_imm = 1'b1;
      end
      default:
      begin
        is_imm = 1'b0;
      end
    endcase
  end

  assign operand = is_imm ? {{(xlen-5){1'b0}}, zimm} : src;

  // set and clear with rs1 = x0 or uimm = 0 must not write
  assign operand_nz = |operand;

  always_comb
  begin
    wdata = old;
    we    = 1'b0;
    case (op)
      op_rw, op_rwi:
      begin
        wdata = operand;
        we    = 1'b1;
      end
      op_rs, op_rsi:
      begin
        wdata = old | operand;
        we    = operand_nz;
      end
      op_rc, op_rci:
      begin
        wdata = old & ~operand;
        we    = operand_nz;
      end
      default:
      begin
        // ecall, mret and idle leave the csr alone
        wdata = old;
        we    = 1'b0;
      end
    endcase
  end

endmodule

// ==== source/csr_pkg.sv ====
package csr_pkg;

  // architectural data width
  localparam int xlen = 32;

  // csr address field of the system instruction
  localparam int csr_addr_w = 12;

  // machine-mode csr addresses
  localparam logic [csr_addr_w-1:0] csr_mstatus   = 12'h300;
  localparam logic [csr_addr_w-1:0] csr_mtvec     = 12'h305;
  localparam logic [csr_addr_w-1:0] csr_mepc      = 12'h341;
  localparam logic [csr_addr_w-1:0] csr_mcause    = 12'h342;
  localparam logic [csr_addr_w-1:0] csr_mvendorid = 12'hF11;
  localparam logic [csr_addr_w-1:0] csr_marchid   = 12'hF12;

  // no writable register lives here, the register block drops writes to it
  localparam logic [csr_addr_w-1:0] csr_none = 12'h000;

  // read-only identification words
  localparam logic [xlen-1:0] mvendorid_val = 32'h7973_7978;
  localparam logic [xlen-1:0] marchid_val   = 32'h015f_de77;

  // slots of the writable registers inside the register block
  localparam int num_regs    = 4;
  localparam int idx_mstatus = 0;
  localparam int idx_mcause  = 1;
  localparam int idx_mepc    = 2;
  localparam int idx_mtvec   = 3;

  // mstatus interrupt enable bits
  localparam int mstatus_mie_bit  = 3;
  localparam int mstatus_mpie_bit = 7;

  // environment call from m-mode
  localparam logic [xlen-1:0] cause_ecall_m = 32'd11;

  // system operation presented by the execute stage
  typedef enum logic [3:0] {
    op_none  = 4'd0,
    // register operand forms
    op_rw    = 4'd1,
    op_rs    = 4'd2,
    op_rc    = 4'd3,
    // immediate operand forms
    op_rwi   = 4'd4,
    op_rsi   = 4'd5,
    op_rci   = 4'd6,
    // trap entry and return
    op_ecall = 4'd7,
    op_mret  = 4'd8
  } csr_op_t;

endpackage

// ==== source/csr_regfile.sv ====
`timescale 1ns/1ps

module csr_regfile
  import csr_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  wen,
  input  logic [csr_addr_w-1:0] waddr0,
  input  logic [xlen-1:0]       wdata0,
  input  logic [csr_addr_w-1:0] waddr1,
  input  logic [xlen-1:0]       wdata1,
  input  logic                  trap_enter,
  input  logic                  trap_return,
  input  logic [csr_addr_w-1:0] raddr,
  output logic [xlen-1:0]       rdata,
  output logic [xlen-1:0]       mtvec,
  output logic [xlen-1:0]       mepc
);

  logic [xlen-1:0]     regs [num_regs];
  logic [xlen-1:0]     regs_nxt [num_regs];
  logic [num_regs-1:0] wsel0;
  logic [num_regs-1:0] wsel1;
  logic [num_regs-1:0] rsel;

  // one-hot register select, all zero for ids and unknown addresses
  function automatic logic [num_regs-1:0] decode_sel(input logic [csr_addr_w-1:0] addr);
    logic [num_regs-1:0] sel;
    sel = '0;
    case (addr)
      csr_mstatus:
      begin
        sel[idx_mstatus] = 1'b1;
      end
      csr_mcause:
      begin
        sel[idx_mcause] = 1'b1;
      end
      csr_mepc:
      begin
        sel[idx_mepc] = 1'b1;
      end
      csr_mtvec:
      begin
        sel[idx_mtvec] = 1'b1;
      end
      default:
      begin
        sel = '0;
      end
    endcase
    return sel;
  endfunction

  assign wsel0 = decode_sel(waddr0);
  assign wsel1 = decode_sel(waddr1);
  assign rsel  = decode_sel(raddr);

  // next state, port 1 after port 0 so it wins on a clash
  always_comb
  begin
    for (int i = 0; i < num_regs; i++)
    begin
      regs_nxt[i] = regs[i];
      if (wen && wsel0[i])
      begin
        regs_nxt[i] = wdata0;
      end
      if (wen && wsel1[i])
      begin
        regs_nxt[i] = wdata1;
      end
    end

    // interrupt enable stack, applied on top of any port write
    if (trap_enter)
    begin
      regs_nxt[idx_mstatus][mstatus_mpie_bit] = regs_nxt[idx_mstatus][mstatus_mie_bit];
      regs_nxt[idx_mstatus][mstatus_mie_bit]  = 1'b0;
    end
    else if (trap_return)
    begin
      regs_nxt[idx_mstatus][mstatus_mie_bit]  = regs_nxt[idx_mstatus][mstatus_mpie_bit];
      regs_nxt[idx_mstatus][mstatus_mpie_bit] = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < num_regs; i++)
      begin
        regs[i] <= '0;
      end
    end
    else
    begin
      regs <= regs_nxt;
    end
  end

  // read mux, unknown addresses return zero
  always_comb
  begin
    rdata = '0;
    case (raddr)
      csr_mvendorid:
      begin
        rdata = mvendorid_val;
      end
      csr_marchid:
      begin
        rdata = marchid_val;
      end
      default:
      begin
        for (int i = 0; i < num_regs; i++)
        begin
          if (rsel[i])
          begin
            rdata = regs[i];
          end
        end
      end
    endcase
  end

  // trap vector and return address for the redirect path
  assign mtvec = regs[idx_mtvec];
  assign mepc  = regs[idx_mepc];

endmodule

// ==== source/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit
  import csr_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  exu_valid,
  input  csr_op_t               op,
  input  logic [csr_addr_w-1:0] csr_addr,
  input  logic [xlen-1:0]       src,
  input  logic [4:0]            zimm,
  input  logic [xlen-1:0]       pc,
  output logic [xlen-1:0]       rdata,
  output logic                  redirect,
  output logic [xlen-1:0]       redirect_pc,
  output logic [xlen-1:0]       mtvec,
  output logic [xlen-1:0]       mepc
);

  // alu request
  logic            csr_we;
  logic [xlen-1:0] csr_wdata;

  // register write ports
  logic                  wen;
  logic [csr_addr_w-1:0] waddr0;
  logic [xlen-1:0]       wdata0;
  logic [csr_addr_w-1:0] waddr1;
  logic [xlen-1:0]       wdata1;

  // mstatus stack control
  logic trap_enter;
  logic trap_return;

  // old value feeds both rd and the read-modify-write
  csr_alu u_alu (
    .op    (op),
    .old   (rdata),
    .src   (src),
    .zimm  (zimm),
    .we    (csr_we),
    .wdata (csr_wdata)
  );

  trap_ctrl u_trap (
    .exu_valid   (exu_valid),
    .op          (op),
    .csr_addr    (csr_addr),
    .csr_we      (csr_we),
    .csr_wdata   (csr_wdata),
    .pc          (pc),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .wen         (wen),
    .waddr0      (waddr0),
    .wdata0      (wdata0),
    .waddr1      (waddr1),
    .wdata1      (wdata1),
    .trap_enter  (trap_enter),
    .trap_return (trap_return),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  csr_regfile u_regs (
    .clk         (clk),
    .rst         (rst),
    .wen         (wen),
    .waddr0      (waddr0),
    .wdata0      (wdata0),
    .waddr1      (waddr1),
    .wdata1      (wdata1),
    .trap_enter  (trap_enter),
    .trap_return (trap_return),
    .raddr       (csr_addr),
    .rdata       (rdata),
    .mtvec       (mtvec),
    .mepc        (mepc)
  );

endmodule

// ==== source/trap_ctrl.sv ====
`timescale 1ns/1ps

module trap_ctrl
  import csr_pkg::*;
(
  input  logic                  exu_valid,
  input  csr_op_t               op,
  input  logic [csr_addr_w-1:0] csr_addr,
  input  logic                  csr_we,
  input  logic [xlen-1:0]       csr_wdata,
  input  logic [xlen-1:0]       pc,
  input  logic [xlen-1:0]       mtvec,
  input  logic [xlen-1:0]       mepc,
  output logic                  wen,
  output logic [csr_addr_w-1:0] waddr0,
  output logic [xlen-1:0]       wdata0,
  output logic [csr_addr_w-1:0] waddr1,
  output logic [xlen-1:0]       wdata1,
  output logic                  trap_enter,
  output logic                  trap_return,
  output logic                  redirect,
  output logic [xlen-1:0]       redirect_pc
);

  logic is_ecall;
  logic is_mret;

  assign is_ecall = exu_valid && (op == op_ecall);
  assign is_mret  = exu_valid && (op == op_mret);

  // write port steering
  always_comb
  begin
    if (is_ecall)
    begin
      // mepc and mcause go in together under a single strobe
      wen    = 1'b1;
      waddr0 = csr_mepc;
      wdata0 = pc;
      waddr1 = csr_mcause;
      wdata1 = cause_ecall_m;
    end
    else
    begin
      // plain csr access, second port parked on a dead address
      wen    = exu_valid && csr_we;
      waddr0 = csr_addr;
      wdata0 = csr_wdata;
      waddr1 = csr_none;
      wdata1 = '0;
    end
  end

  // mstatus bit updates
  assign trap_enter  = is_ecall;
  assign trap_return = is_mret;

  // pc redirect
  assign redirect = is_ecall || is_mret;

  // direct mode only, so the mode bits of mtvec are dropped
  always_comb
  begin
    if (is_ecall)
    begin
      redirect_pc = {mtvec[xlen-1:2], 2'b00};
    end
    else
    begin
      redirect_pc = mepc;
    end
  end

endmodule

// ==== verif/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb
  import csr_pkg::*;
();

  // run length and cycle budget
  localparam int reset_cycles    = 4;
  localparam int directed_cycles = 80;
  localparam int random_cycles   = 220;
  localparam int timeout_cycles  = reset_cycles + directed_cycles + random_cycles + 96;

  // an address with no csr behind it
  localparam logic [csr_addr_w-1:0] addr_unknown = 12'h7c0;

  logic                  clk;
  logic                  rst;
  logic                  exu_valid;
  csr_op_t               op;
  logic [csr_addr_w-1:0] csr_addr;
  logic [xlen-1:0]       src;
  logic [4:0]            zimm;
  logic [xlen-1:0]       pc;
  logic [xlen-1:0]       rdata;
  logic                  redirect;
  logic [xlen-1:0]       redirect_pc;
  logic [xlen-1:0]       mtvec;
  logic [xlen-1:0]       mepc;

  // reference copies of the writable registers
  logic [xlen-1:0] m_mstatus;
  logic [xlen-1:0] m_mcause;
  logic [xlen-1:0] m_mepc;
  logic [xlen-1:0] m_mtvec;

  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          cycle_count;

  csr_unit uut (
    .clk         (clk),
    .rst         (rst),
    .exu_valid   (exu_valid),
    .op          (op),
    .csr_addr    (csr_addr),
    .src         (src),
    .zimm        (zimm),
    .pc          (pc),
    .rdata       (rdata),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .mtvec       (mtvec),
    .mepc        (mepc)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic csr_op_t pick_op(input logic [31:0] r);
    int unsigned k;
    k = r[15:8] % 9;
    case (k)
      0: return op_none;
      1: return op_rw;
      2: return op_rs;
      3: return op_rc;
      4: return op_rwi;
      5: return op_rsi;
      6: return op_rci;
      7: return op_ecall;
      default: return op_mret;
    endcase
  endfunction

  function automatic logic [csr_addr_w-1:0] pick_addr(input logic [31:0] r);
    case (r[18:16])
      3'd0: return csr_mstatus;
      3'd1: return csr_mcause;
      3'd2: return csr_mepc;
      3'd3: return csr_mtvec;
      3'd4: return csr_mvendorid;
      3'd5: return csr_marchid;
      3'd6: return addr_unknown;
      default: return 12'h340;
    endcase
  endfunction

  // value an architectural read of the address returns
  function automatic logic [xlen-1:0] expected_read(input logic [csr_addr_w-1:0] addr);
    case (addr)
      csr_mstatus:   return m_mstatus;
      csr_mcause:    return m_mcause;
      csr_mepc:      return m_mepc;
      csr_mtvec:     return m_mtvec;
      csr_mvendorid: return mvendorid_val;
      csr_marchid:   return marchid_val;
      default:       return '0;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [xlen-1:0] exp_val,
                                 input logic [xlen-1:0] act_val);
    errors++;
    $display("Fail %s: expected %h, actual %h at %0t", name, exp_val, act_val, $time);
  endtask

  // one instruction slot entered just after a rising edge
  task automatic run_cycle(input logic valid_in, input csr_op_t op_in,
                           input logic [csr_addr_w-1:0] addr_in, input logic [xlen-1:0] src_in,
                           input logic [4:0] zimm_in, input logic [xlen-1:0] pc_in);
    logic [xlen-1:0] old_val;
    logic [xlen-1:0] operand;
    logic [xlen-1:0] new_val;
    logic            write_req;
    logic            exp_redirect;
    logic [xlen-1:0] exp_target;
    logic [xlen-1:0] n_mstatus;
    logic [xlen-1:0] n_mcause;
    logic [xlen-1:0] n_mepc;
    logic [xlen-1:0] n_mtvec;

    #2;
    exu_valid = valid_in;
    op        = op_in;
    csr_addr  = addr_in;
    src       = src_in;
    zimm      = zimm_in;
    pc        = pc_in;

    old_val = expected_read(addr_in);
    if (op_in == op_rwi || op_in == op_rsi || op_in == op_rci)
    begin
      operand = {27'd0, zimm_in};
    end
    else
    begin
      operand = src_in;
    end

    new_val   = old_val;
    write_req = 1'b0;
    case (op_in)
      op_rw, op_rwi:
      begin
        new_val   = operand;
        write_req = 1'b1;
      end
      op_rs, op_rsi:
      begin
        new_val   = old_val | operand;
        write_req = (operand != '0);
      end
      op_rc, op_rci:
      begin
        new_val   = old_val & ~operand;
        write_req = (operand != '0);
      end
      default:
      begin
        write_req = 1'b0;
      end
    endcase

    exp_redirect = valid_in && (op_in == op_ecall || op_in == op_mret);
    exp_target   = (op_in == op_ecall) ? (m_mtvec & 32'hffff_fffc) : m_mepc;

    // outputs settle well before the falling edge
    @(negedge clk);
    checks += 4;
    assert (rdata === old_val)
    else report_mismatch("rdata", old_val, rdata);
    assert (redirect === exp_redirect)
    else report_mismatch("redirect", exp_redirect, redirect);
    assert (mtvec === m_mtvec)
    else report_mismatch("mtvec", m_mtvec, mtvec);
    assert (mepc === m_mepc)
    else report_mismatch("mepc", m_mepc, mepc);
    if (exp_redirect)
    begin
      checks++;
      assert (redirect_pc === exp_target)
      else report_mismatch("redirect_pc", exp_target, redirect_pc);
    end

    n_mstatus = m_mstatus;
    n_mcause  = m_mcause;
    n_mepc    = m_mepc;
    n_mtvec   = m_mtvec;
    if (valid_in && write_req)
    begin
      case (addr_in)
        csr_mstatus: n_mstatus = new_val;
        csr_mcause:  n_mcause  = new_val;
        csr_mepc:    n_mepc    = new_val;
        csr_mtvec:   n_mtvec   = new_val;
        default:     n_mstatus = m_mstatus;
      endcase
    end
    if (valid_in && op_in == op_ecall)
    begin
      n_mepc                      = pc_in;
      n_mcause                    = 32'd11;
      n_mstatus[mstatus_mpie_bit] = m_mstatus[mstatus_mie_bit];
      n_mstatus[mstatus_mie_bit]  = 1'b0;
    end
    if (valid_in && op_in == op_mret)
    begin
      n_mstatus[mstatus_mie_bit]  = m_mstatus[mstatus_mpie_bit];
      n_mstatus[mstatus_mpie_bit] = 1'b1;
    end

    @(posedge clk);
    m_mstatus = n_mstatus;
    m_mcause  = n_mcause;
    m_mepc    = n_mepc;
    m_mtvec   = n_mtvec;
  endtask

  // plain read as csrrs with a zero operand
  task automatic read_csr(input logic [csr_addr_w-1:0] addr);
    run_cycle(1'b1, op_rs, addr, '0, 5'd0, '0);
  endtask

  initial
  begin : watchdog
    cycle_count = 0;
    while (cycle_count < timeout_cycles)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the test sequence did not finish within %0d cycles", timeout_cycles);
    $display("errors: %0d, checks: %0d", errors, checks);
    $display("CHECKS FAILED");
    $finish;
  end

  initial
  begin
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;

    clk       = 1'b0;
    rst       = 1'b1;
    exu_valid = 1'b0;
    op        = op_none;
    csr_addr  = '0;
    src       = '0;
    zimm      = '0;
    pc        = '0;
    rng_state = 32'h623b;
    errors    = 0;
    checks    = 0;
    m_mstatus = '0;
    m_mcause  = '0;
    m_mepc    = '0;
    m_mtvec   = '0;

    repeat (reset_cycles) @(posedge clk);
    #2;
    rst = 1'b0;
    @(posedge clk);

    // reset values and constant ids
    read_csr(csr_mstatus);
    read_csr(csr_mcause);
    read_csr(csr_mepc);
    read_csr(csr_mtvec);
    read_csr(csr_mvendorid);
    read_csr(csr_marchid);
    read_csr(addr_unknown);

    // swap, set and clear forms
    run_cycle(1'b1, op_rw, csr_mtvec, 32'h8000_0103, 5'd0, '0);
    read_csr(csr_mtvec);
    run_cycle(1'b1, op_rwi, csr_mepc, 32'hffff_ffff, 5'h15, '0);
    read_csr(csr_mepc);
    run_cycle(1'b1, op_rs, csr_mstatus, 32'h0000_0088, 5'd0, '0);
    run_cycle(1'b1, op_rc, csr_mstatus, 32'h0000_0080, 5'd0, '0);
    read_csr(csr_mstatus);
    run_cycle(1'b1, op_rw, csr_mcause, 32'hdead_beef, 5'd0, '0);
    run_cycle(1'b1, op_rsi, csr_mcause, '0, 5'h10, '0);
    run_cycle(1'b1, op_rci, csr_mcause, '0, 5'h0f, '0);
    run_cycle(1'b1, op_rsi, csr_mcause, 32'hffff_ffff, 5'd0, '0);
    run_cycle(1'b1, op_rci, csr_mcause, 32'hffff_ffff, 5'd0, '0);
    run_cycle(1'b1, op_rc, csr_mcause, '0, 5'h1f, '0);
    read_csr(csr_mcause);

    // read-only and unmapped targets
    run_cycle(1'b1, op_rw, csr_mvendorid, 32'h1234_5678, 5'd0, '0);
    run_cycle(1'b1, op_rs, csr_marchid, 32'hffff_ffff, 5'd0, '0);
    run_cycle(1'b1, op_rc, addr_unknown, 32'hffff_ffff, 5'd0, '0);
    run_cycle(1'b1, op_rwi, 12'h340, '0, 5'h1f, '0);
    read_csr(csr_mvendorid);
    read_csr(csr_marchid);
    read_csr(addr_unknown);
    read_csr(12'h340);

    // trap entry
    run_cycle(1'b1, op_rsi, csr_mstatus, '0, 5'h08, '0);
    run_cycle(1'b1, op_rw, csr_mtvec, 32'h0000_1003, 5'd0, '0);
    run_cycle(1'b1, op_ecall, csr_mstatus, '0, 5'd0, 32'h0000_0400);
    read_csr(csr_mepc);
    read_csr(csr_mcause);
    read_csr(csr_mstatus);

    // trap return then idle slots carrying live ops
    run_cycle(1'b1, op_rw, csr_mepc, 32'h0000_0a04, 5'd0, '0);
    run_cycle(1'b1, op_mret, csr_mstatus, '0, 5'd0, '0);
    read_csr(csr_mstatus);
    run_cycle(1'b0, op_ecall, csr_mstatus, '0, 5'd0, 32'h0000_0800);
    run_cycle(1'b0, op_mret, csr_mepc, '0, 5'd0, '0);
    run_cycle(1'b0, op_rw, csr_mtvec, 32'hffff_fff0, 5'd0, '0);
    read_csr(csr_mtvec);
    read_csr(csr_mepc);
    read_csr(csr_mstatus);
    run_cycle(1'b1, op_ecall, csr_mcause, '0, 5'd0, 32'h0000_0c10);
    run_cycle(1'b1, op_mret, csr_mcause, '0, 5'd0, '0);
    read_csr(csr_mstatus);

    // mie and mpie differ before entry and before return
    run_cycle(1'b1, op_rw, csr_mstatus, 32'h0000_0080, 5'd0, '0);
    run_cycle(1'b1, op_ecall, csr_mcause, '0, 5'd0, 32'h0000_0d00);
    read_csr(csr_mstatus);
    run_cycle(1'b1, op_rw, csr_mstatus, 32'h0000_0008, 5'd0, '0);
    run_cycle(1'b1, op_mret, csr_mstatus, '0, 5'd0, '0);
    read_csr(csr_mstatus);

    // random back-to-back traffic
    for (int i = 0; i < random_cycles; i++)
    begin
      r0 = next_rand();
      r1 = next_rand();
      r2 = next_rand();
      run_cycle(r0[31:29] != 3'b000, pick_op(r0), pick_addr(r0),
                (r1[7:5] == 3'b000) ? 32'd0 : r1, r0[4:0], {r2[31:2], 2'b00});
    end

    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0 && checks > 0)
    begin
      $display("ALL CHECKS PASSED");
    end
    else
    begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
